//--- verilog/iob_bus_defines.svh
`ifndef IOB_BUS_DEFINES_SVH
`define IOB_BUS_DEFINES_SVH

// native bus widths
`define IOB_DATA_W 32
`define IOB_ADDR_W 16

// one strobe bit per data byte
`define IOB_STRB_W 4

// masters sharing the bus at the top level
`define IOB_N_MASTERS 2

// sram depth in words
`define IOB_MEM_WORDS 256

`endif

//--- verilog/iob_bus_pkg.sv
`default_nettype none

`include "iob_bus_defines.svh"

package iob_bus_pkg;

   typedef logic [`IOB_DATA_W-1:0] data_t;
   typedef logic [`IOB_ADDR_W-1:0] addr_t;

   // nonzero strobe means write, zero means read
   typedef logic [`IOB_STRB_W-1:0] strb_t;

   // master index of at least one bit
   typedef logic [((`IOB_N_MASTERS > 1) ? $clog2(`IOB_N_MASTERS) : 1)-1:0] midx_t;

endpackage

`default_nettype wire

//--- verilog/iob_merge.sv
`timescale 1ns/100ps
`default_nettype none

module iob_merge
   import iob_bus_pkg::*;
#(
   parameter int N_MASTERS = 2
) (
   input  wire logic                    clk_i,
   input  wire logic                    rst_i,

   // master side with one slot per master
   input  wire logic  [N_MASTERS-1:0]   m_valid_i,
   input  wire addr_t [N_MASTERS-1:0]   m_addr_i,
   input  wire data_t [N_MASTERS-1:0]   m_wdata_i,
   input  wire strb_t [N_MASTERS-1:0]   m_wstrb_i,
   output      data_t [N_MASTERS-1:0]   m_rdata_o,
   output      logic  [N_MASTERS-1:0]   m_ready_o,

   // shared slave side
   output      logic                    s_valid_o,
   output      addr_t                   s_addr_o,
   output      data_t                   s_wdata_o,
   output      strb_t                   s_wstrb_o,
   input  wire data_t                   s_rdata_i,
   input  wire logic                    s_ready_i
);

   logic  lock_q;
   midx_t sel_q;
   midx_t grant;

   // highest index wins while unlocked, otherwise hold the locked master
   always_comb begin
      grant = sel_q;
      if (!lock_q) begin
         grant = '0;
         for (int k = 0; k < N_MASTERS; k++) begin
            if (m_valid_i[k]) begin
               grant = midx_t'(k);
            end
         end
      end
   end

   // forward the granted request
   assign s_valid_o = m_valid_i[grant];
   assign s_addr_o  = m_addr_i[grant];
   assign s_wdata_o = m_wdata_i[grant];
   assign s_wstrb_o = m_wstrb_i[grant];

   // lock on forward, release the cycle after the slave answers
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         lock_q <= 1'b0;
         sel_q  <= '0;
      end else if (lock_q) begin
         if (s_ready_i) begin
            lock_q <= 1'b0;
         end
      end else begin
         sel_q  <= grant;
         lock_q <= s_valid_o;
      end
   end

   // response only reaches the locked master
   always_comb begin
      m_rdata_o = '0;
      m_ready_o = '0;
      m_rdata_o[sel_q] = s_rdata_i;
      m_ready_o[sel_q] = s_ready_i & lock_q;
   end

endmodule

`default_nettype wire

//--- verilog/iob_split.sv
`timescale 1ns/100ps
`default_nettype none

module iob_split
   import iob_bus_pkg::*;
(
   input  wire logic  clk_i,
   input  wire logic  rst_i,

   // upstream master bus
   input  wire logic  m_valid_i,
   input  wire addr_t m_addr_i,
   input  wire data_t m_wdata_i,
   input  wire strb_t m_wstrb_i,
   output      data_t m_rdata_o,
   output      logic  m_ready_o,

   // slave 0 is the sram
   output      logic  s0_valid_o,
   output      addr_t s0_addr_o,
   output      data_t s0_wdata_o,
   output      strb_t s0_wstrb_o,
   input  wire data_t s0_rdata_i,
   input  wire logic  s0_ready_i,

   // slave 1 is the register block
   output      logic  s1_valid_o,
   output      addr_t s1_addr_o,
   output      data_t s1_wdata_o,
   output      strb_t s1_wstrb_o,
   input  wire data_t s1_rdata_i,
   input  wire logic  s1_ready_i
);

   logic  req_sel;
   logic  sel_q;
   addr_t local_addr;

   // top address bit picks the slave
   assign req_sel    = m_addr_i[$bits(addr_t)-1];
   assign local_addr = {1'b0, m_addr_i[$bits(addr_t)-2:0]};

   assign s0_valid_o = m_valid_i & ~req_sel;
   assign s0_addr_o  = local_addr;
   assign s0_wdata_o = m_wdata_i;
   assign s0_wstrb_o = m_wstrb_i;

   assign s1_valid_o = m_valid_i & req_sel;
   assign s1_addr_o  = local_addr;
   assign s1_wdata_o = m_wdata_i;
   assign s1_wstrb_o = m_wstrb_i;

   // remember which slave owes the response
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         sel_q <= 1'b0;
      end else if (m_valid_i) begin
         sel_q <= req_sel;
      end
   end

   assign m_rdata_o = sel_q ? s1_rdata_i : s0_rdata_i;
   assign m_ready_o = sel_q ? s1_ready_i : s0_ready_i;

endmodule

`default_nettype wire

//--- verilog/iob_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_defines.svh"

module iob_sram
   import iob_bus_pkg::*;
(
   input  wire logic  clk_i,
   input  wire logic  rst_i,
   input  wire logic  valid_i,
   input  wire addr_t addr_i,
   input  wire data_t wdata_i,
   input  wire strb_t wstrb_i,
   output      data_t rdata_o,
   output      logic  ready_o
);

   localparam int IDX_W = $clog2(`IOB_MEM_WORDS);

   data_t            mem [`IOB_MEM_WORDS];
   logic             accept;
   logic [IDX_W-1:0] idx;

   // no new request during the ready cycle
   assign accept = valid_i & ~ready_o;

   // word index from the byte address
   assign idx = addr_i[IDX_W+1:2];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ready_o <= 1'b0;
      end else begin
         ready_o <= accept;
      end
   end

   // read returns the old word, then the strobed bytes are written
   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdata_o <= mem[idx];
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wstrb_i[b]) begin
               mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/iob_gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module iob_gpio_regs
   import iob_bus_pkg::*;
(
   input  wire logic  clk_i,
   input  wire logic  rst_i,
   input  wire logic  valid_i,
   input  wire addr_t addr_i,
   input  wire data_t wdata_i,
   input  wire strb_t wstrb_i,
   output      data_t rdata_o,
   output      logic  ready_o,
   output      data_t gpio_o,
   input  wire data_t gpio_i
);

   data_t      gpio_q;
   data_t      scratch_q;
   data_t      wcount_q;
   data_t      rd_word;
   logic       accept;
   logic       wr_en;
   logic [1:0] offset;

   // merge strobed bytes of a new word into an old one
   function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
      data_t res;
      res = old_w;
      for (int b = 0; b < $bits(strb_t); b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign accept = valid_i & ~ready_o;
   assign wr_en  = accept & (|wstrb_i);
   assign offset = addr_i[3:2];

   always_comb begin
      case (offset)
         2'd0:    rd_word = gpio_q;
         2'd1:    rd_word = scratch_q;
         2'd2:    rd_word = wcount_q;
         default: rd_word = gpio_i;
      endcase
   end

   // offsets 2 and 3 are read-only, writes there only bump the counter
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ready_o   <= 1'b0;
         gpio_q    <= '0;
         scratch_q <= '0;
         wcount_q  <= '0;
      end else begin
         ready_o <= accept;
         if (wr_en) begin
            wcount_q <= wcount_q + 1'b1;
            if (offset == 2'd0) begin
               gpio_q <= merge_bytes(gpio_q, wdata_i, wstrb_i);
            end
            if (offset == 2'd1) begin
               scratch_q <= merge_bytes(scratch_q, wdata_i, wstrb_i);
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdata_o <= rd_word;
      end
   end

   assign gpio_o = gpio_q;

endmodule

`default_nettype wire

//--- verilog/iob_system.sv
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_defines.svh"

module iob_system
   import iob_bus_pkg::*;
(
   input  wire logic  clk_i,
   input  wire logic  rst_i,

   // master 0
   input  wire logic  m0_valid_i,
   input  wire addr_t m0_addr_i,
   input  wire data_t m0_wdata_i,
   input  wire strb_t m0_wstrb_i,
   output      data_t m0_rdata_o,
   output      logic  m0_ready_o,

   // master 1 has the higher priority
   input  wire logic  m1_valid_i,
   input  wire addr_t m1_addr_i,
   input  wire data_t m1_wdata_i,
   input  wire strb_t m1_wstrb_i,
   output      data_t m1_rdata_o,
   output      logic  m1_ready_o,

   output      data_t gpio_o,
   input  wire data_t gpio_i
);

   data_t [`IOB_N_MASTERS-1:0] m_rdata;
   logic  [`IOB_N_MASTERS-1:0] m_ready;

   // shared bus between merge and split
   logic  bus_valid;
   addr_t bus_addr;
   data_t bus_wdata;
   strb_t bus_wstrb;
   data_t bus_rdata;
   logic  bus_ready;

   // split to sram
   logic  mem_valid;
   addr_t mem_addr;
   data_t mem_wdata;
   strb_t mem_wstrb;
   data_t mem_rdata;
   logic  mem_ready;

   // split to register block
   logic  reg_valid;
   addr_t reg_addr;
   data_t reg_wdata;
   strb_t reg_wstrb;
   data_t reg_rdata;
   logic  reg_ready;

   assign m0_rdata_o = m_rdata[0];
   assign m0_ready_o = m_ready[0];
   assign m1_rdata_o = m_rdata[1];
   assign m1_ready_o = m_ready[1];

   iob_merge #(
      .N_MASTERS (`IOB_N_MASTERS)
   ) merge (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .m_valid_i ({m1_valid_i, m0_valid_i}),
      .m_addr_i  ({m1_addr_i, m0_addr_i}),
      .m_wdata_i ({m1_wdata_i, m0_wdata_i}),
      .m_wstrb_i ({m1_wstrb_i, m0_wstrb_i}),
      .m_rdata_o (m_rdata),
      .m_ready_o (m_ready),
      .s_valid_o (bus_valid),
      .s_addr_o  (bus_addr),
      .s_wdata_o (bus_wdata),
      .s_wstrb_o (bus_wstrb),
      .s_rdata_i (bus_rdata),
      .s_ready_i (bus_ready)
   );

   iob_split split (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .m_valid_i  (bus_valid),
      .m_addr_i   (bus_addr),
      .m_wdata_i  (bus_wdata),
      .m_wstrb_i  (bus_wstrb),
      .m_rdata_o  (bus_rdata),
      .m_ready_o  (bus_ready),
      .s0_valid_o (mem_valid),
      .s0_addr_o  (mem_addr),
      .s0_wdata_o (mem_wdata),
      .s0_wstrb_o (mem_wstrb),
      .s0_rdata_i (mem_rdata),
      .s0_ready_i (mem_ready),
      .s1_valid_o (reg_valid),
      .s1_addr_o  (reg_addr),
      .s1_wdata_o (reg_wdata),
      .s1_wstrb_o (reg_wstrb),
      .s1_rdata_i (reg_rdata),
      .s1_ready_i (reg_ready)
   );

   iob_sram sram (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (mem_valid),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .wstrb_i (mem_wstrb),
      .rdata_o (mem_rdata),
      .ready_o (mem_ready)
   );

   iob_gpio_regs regs (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (reg_valid),
      .addr_i  (reg_addr),
      .wdata_i (reg_wdata),
      .wstrb_i (reg_wstrb),
      .rdata_o (reg_rdata),
      .ready_o (reg_ready),
      .gpio_o  (gpio_o),
      .gpio_i  (gpio_i)
   );

endmodule

`default_nettype wire

//--- testbench/iob_system_properties.sv
`timescale 1ns/100ps
`default_nettype none

module iob_system_properties
   import iob_bus_pkg::*;
#(
   parameter int N_MASTERS = 2
) (
   input wire logic                  clk_i,
   input wire logic                  rst_i,
   input wire logic  [N_MASTERS-1:0] m_valid_i,
   input wire addr_t [N_MASTERS-1:0] m_addr_i,
   // merge outputs observed here as inputs
   input wire logic  [N_MASTERS-1:0] m_ready_o,
   input wire logic                  s_valid_o,
   input wire addr_t                 s_addr_o,
   input wire logic                  s_ready_i
);

   // at most one response per cycle
   one_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(m_ready_o))
      else $error("more than one master saw ready in the same cycle");

   // ready only to the master whose request was forwarded and which still holds valid
   for (genvar k = 0; k < N_MASTERS; k++) begin : g_owner
      ready_to_owner: assert property (@(posedge clk_i) disable iff (rst_i)
         m_ready_o[k] |-> (m_valid_i[k] && $past(s_valid_o && (s_addr_o == m_addr_i[k]))))
         else $error("master %0d saw ready for a request that was not forwarded", k);
   end

   // request held on the slave side until served
   request_held: assert property (@(posedge clk_i) disable iff (rst_i)
      (s_valid_o && !s_ready_i) |=> (s_valid_o && $stable(s_addr_o)))
      else $error("slave request dropped or changed before ready");

endmodule

bind iob_merge iob_system_properties #(
   .N_MASTERS (N_MASTERS)
) props (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .m_valid_i (m_valid_i),
   .m_addr_i  (m_addr_i),
   .m_ready_o (m_ready_o),
   .s_valid_o (s_valid_o),
   .s_addr_o  (s_addr_o),
   .s_ready_i (s_ready_i)
);

`default_nettype wire

//--- testbench/tb_iob_system.sv
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_defines.svh"

module tb_iob_system
   import iob_bus_pkg::*;
();

   localparam addr_t REG_BASE    = 16'h8000;
   localparam int    TIMEOUT_CYC = 20;
   localparam int    MEM_WORDS   = `IOB_MEM_WORDS;

   logic  clk_i;
   logic  rst_i;
   logic  m0_valid_i;
   addr_t m0_addr_i;
   data_t m0_wdata_i;
   strb_t m0_wstrb_i;
   data_t m0_rdata_o;
   logic  m0_ready_o;
   logic  m1_valid_i;
   addr_t m1_addr_i;
   data_t m1_wdata_i;
   strb_t m1_wstrb_i;
   data_t m1_rdata_o;
   logic  m1_ready_o;
   data_t gpio_o;
   data_t gpio_i;

   // reference model
   data_t model_mem [MEM_WORDS];
   data_t model_gpio;
   data_t model_scratch;
   data_t model_wcount;

   int cycle = 0;
   int checks = 0;
   int check_errors = 0;
   int timeout_errors = 0;

   iob_system uut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .m0_valid_i (m0_valid_i),
      .m0_addr_i  (m0_addr_i),
      .m0_wdata_i (m0_wdata_i),
      .m0_wstrb_i (m0_wstrb_i),
      .m0_rdata_o (m0_rdata_o),
      .m0_ready_o (m0_ready_o),
      .m1_valid_i (m1_valid_i),
      .m1_addr_i  (m1_addr_i),
      .m1_wdata_i (m1_wdata_i),
      .m1_wstrb_i (m1_wstrb_i),
      .m1_rdata_o (m1_rdata_o),
      .m1_ready_o (m1_ready_o),
      .gpio_o     (gpio_o),
      .gpio_i     (gpio_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle <= cycle + 1;
   end

   // byte mask from the strobes blends old and new
   function automatic data_t apply_strobes(data_t old_w, data_t new_w, strb_t strb);
      data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   task automatic check_word(input string name, input data_t exp, input data_t act);
      checks++;
      assert (act === exp) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
         check_errors++;
      end
   endtask

   task automatic drive_req(input int m, input logic v, input addr_t a, input data_t d,
                            input strb_t s);
      if (m == 0) begin
         m0_valid_i = v;
         m0_addr_i  = a;
         m0_wdata_i = d;
         m0_wstrb_i = s;
      end else begin
         m1_valid_i = v;
         m1_addr_i  = a;
         m1_wdata_i = d;
         m1_wstrb_i = s;
      end
   endtask

   // called just after a rising edge and returns just after one
   task automatic bus_access(input int m, input addr_t addr, input data_t wdata,
                             input strb_t strb, output data_t rdata, output int done_cyc);
      int   waited;
      logic seen;
      waited   = 0;
      seen     = 1'b0;
      rdata    = '0;
      done_cyc = -1;
      drive_req(m, 1'b1, addr, wdata, strb);
      while (!seen && waited < TIMEOUT_CYC) begin
         @(negedge clk_i);
         waited++;
         if ((m == 0) ? m0_ready_o : m1_ready_o) begin
            seen     = 1'b1;
            rdata    = (m == 0) ? m0_rdata_o : m1_rdata_o;
            done_cyc = cycle;
         end
      end
      if (!seen) begin
         $display("timeout: master %0d got no ready for address %h", m, addr);
         timeout_errors++;
      end
      @(posedge clk_i);
      #2;
      drive_req(m, 1'b0, '0, '0, '0);
   endtask

   // sram returns the old word on reads and writes alike
   task automatic mem_access(input int m, input string name, input int idx,
                             input data_t wdata, input strb_t strb, input logic check,
                             output int cyc);
      data_t exp;
      data_t rd;
      exp = model_mem[idx];
      bus_access(m, addr_t'(idx << 2), wdata, strb, rd, cyc);
      if (check) begin
         check_word(name, exp, rd);
      end
      model_mem[idx] = apply_strobes(exp, wdata, strb);
   endtask

   task automatic reg_access(input int m, input string name, input int off,
                             input data_t wdata, input strb_t strb, output int cyc);
      data_t exp;
      data_t rd;
      case (off)
         0:       exp = model_gpio;
         1:       exp = model_scratch;
         2:       exp = model_wcount;
         default: exp = gpio_i;
      endcase
      bus_access(m, REG_BASE | addr_t'(off << 2), wdata, strb, rd, cyc);
      check_word(name, exp, rd);
      if (strb != '0) begin
         model_wcount++;
         if (off == 0) begin
            model_gpio = apply_strobes(model_gpio, wdata, strb);
         end
         if (off == 1) begin
            model_scratch = apply_strobes(model_scratch, wdata, strb);
         end
      end
   endtask

   initial begin
      data_t wd;
      strb_t st;
      int    idx;
      int    c0;
      int    c1;
      void'($urandom(35548));
      rst_i         = 1'b1;
      gpio_i        = $urandom;
      model_gpio    = '0;
      model_scratch = '0;
      model_wcount  = '0;
      drive_req(0, 1'b0, '0, '0, '0);
      drive_req(1, 1'b0, '0, '0, '0);
      repeat (5) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      // reset state
      assert (!m0_ready_o && !m1_ready_o) else begin
         $display("a master ready output is high right after reset");
         check_errors++;
      end
      check_word("reset gpio_o", '0, gpio_o);
      reg_access(0, "reset write count", 2, '0, '0, c0);

      // register block
      reg_access(0, "gpio full write", 0, $urandom, 4'hf, c0);
      check_word("gpio_o after full write", model_gpio, gpio_o);
      reg_access(0, "gpio partial write", 0, $urandom, 4'b0101, c0);
      check_word("gpio_o after partial write", model_gpio, gpio_o);
      reg_access(0, "gpio read", 0, '0, '0, c0);
      reg_access(0, "scratch write", 1, $urandom, 4'hf, c0);
      reg_access(0, "scratch read", 1, '0, '0, c0);
      reg_access(0, "gpio_i read", 3, '0, '0, c0);
      reg_access(0, "gpio_i write", 3, $urandom, 4'hf, c0);
      reg_access(0, "gpio_i read after write", 3, '0, '0, c0);
      reg_access(0, "write count", 2, '0, '0, c0);

      // sram contents are unknown until filled
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_access(0, "sram fill", i, $urandom, 4'hf, 1'b0, c0);
      end
      for (int i = 0; i < 16; i++) begin
         idx = $urandom % MEM_WORDS;
         wd  = $urandom;
         st  = strb_t'($urandom);
         mem_access(0, "sram strobed write", idx, wd, st, 1'b1, c0);
         mem_access(0, "sram read back", idx, '0, '0, 1'b1, c0);
      end

      // both masters at once on an idle bus
      fork
         mem_access(0, "contention master 0 read", 5, '0, '0, 1'b1, c0);
         reg_access(1, "contention master 1 read", 1, '0, '0, c1);
      join
      assert (c1 < c0) else begin
         $display("master 0 served in cycle %0d before master 1 in cycle %0d", c0, c1);
         check_errors++;
      end

      // master 1 arrives while master 0 holds the grant
      fork
         mem_access(0, "lock master 0 write", 7, $urandom, 4'hf, 1'b1, c0);
         begin
            @(posedge clk_i);
            #2;
            reg_access(1, "lock master 1 read", 0, '0, '0, c1);
         end
      join
      assert (c0 < c1) else begin
         $display("master 1 took the bus from master 0 during a locked transfer");
         check_errors++;
      end

      // same low address bits, different slaves
      mem_access(0, "split sram write", 1, $urandom, 4'hf, 1'b1, c0);
      reg_access(0, "split scratch write", 1, $urandom, 4'hf, c0);
      mem_access(0, "split sram read", 1, '0, '0, 1'b1, c0);
      reg_access(0, "split scratch read", 1, '0, '0, c0);
      reg_access(1, "final write count", 2, '0, '0, c0);

      $display("checks %0d, value errors %0d, timeouts %0d",
               checks, check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/iob_bus_pkg.sv
verilog/iob_merge.sv
verilog/iob_split.sv
verilog/iob_sram.sv
verilog/iob_gpio_regs.sv
verilog/iob_system.sv
testbench/iob_system_properties.sv
testbench/tb_iob_system.sv

//--- Makefile
TOP = tb_iob_system

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
